//--- hdl/ea_params.svh
// EA unit constants
// Widths, operand queue depth and register codes
`ifndef EA_PARAMS_SVH
`define EA_PARAMS_SVH

`define EA_ADDR_W        24
`define EA_WORD_W        16
`define EA_REG_W         32
`define EA_CODE_W        8
`define EA_STEP_W        2
`define EA_QUEUE_DEPTH   4      // Operand words
`define EA_NULL_REG      8'h40  // Reads as zero
`define EA_FULL_REG_BASE 8'he0  // XWA, then +4 up to XSP

`endif

//--- hdl/ea_pkg.sv
// EA unit types
// Address, register and operand word types shared across the unit
`include "ea_params.svh"

package ea_pkg;

    typedef logic [`EA_ADDR_W-1:0] addr_t;     // Byte address
    typedef logic [`EA_CODE_W-1:0] reg_code_t;
    typedef logic [`EA_REG_W-1:0]  reg_word_t;
    typedef logic [`EA_WORD_W-1:0] op_word_t;  // Also the memory word
    typedef logic [`EA_STEP_W-1:0] step_t;     // 0/1/2 for 1/2/4 bytes

    // Code of full register XWA..XSP from its 3-bit index
    function automatic reg_code_t full_reg(input logic [2:0] idx);
        return reg_code_t'(`EA_FULL_REG_BASE + {idx, 2'b00});
    endfunction

    function automatic reg_word_t step_size(input step_t step);
        reg_word_t size;
        case (step)
            2'd0:    size = 32'd1;
            2'd1:    size = 32'd2;
            2'd2:    size = 32'd4;
            default: size = '0;  // Undefined step, no move
        endcase
        return size;
    endfunction

endpackage

//--- hdl/mem_port_if.sv
// Memory request port
// One requester's view of the shared memory bus
interface mem_port_if;
    logic             req;    // Held until ack
    ea_pkg::addr_t    addr;   // Stable while req is high
    ea_pkg::op_word_t rdata;  // Valid in the ack cycle
    logic             ack;

    modport requester (
        output req,
        output addr,
        input  rdata,
        input  ack
    );

    modport arbiter (
        input  req,
        input  addr,
        output rdata,
        output ack
    );
endinterface

//--- hdl/reg_access_if.sv
// Register bank access
// Base and index read ports plus step update controls
interface reg_access_if;
    ea_pkg::reg_code_t sel;        // Base register
    ea_pkg::reg_word_t rdata;
    ea_pkg::reg_code_t aux_sel;    // Index register
    ea_pkg::reg_word_t aux_rdata;
    ea_pkg::step_t     step;
    logic              inc;
    logic              dec;

    modport master (
        output sel, aux_sel, step, inc, dec,
        input  rdata, aux_rdata
    );

    modport slave (
        input  sel, aux_sel, step, inc, dec,
        output rdata, aux_rdata
    );
endinterface

//--- hdl/ea_addr_gen.sv
// Effective-address generator
// Decodes operand descriptors, takes extension words and forms 24-bit addresses
`include "ea_params.svh"

module ea_addr_gen (
    input  logic             clk,
    input  logic             rst,
    input  ea_pkg::op_word_t op_word,
    input  logic             op_valid,
    output logic             op_take,
    reg_access_if.master     regs,
    output ea_pkg::addr_t    ea,
    output logic             ea_ok,
    input  logic             reader_busy
);
    import ea_pkg::*;

    typedef enum logic {ST_IDLE, ST_EXT} state_t;

    state_t     state;
    logic [4:0] mode;        // Mode of the operand waiting for its extension
    logic [1:0] variant;     // Bits 9:8 of the first word
    logic       idx16;
    addr_t      offset;
    addr_t      idx_ext;
    logic [4:0] cur_mode;
    logic       take_first;
    logic       take_ext;
    logic       done_first;  // First word alone completes the operand
    logic       need_ext;

    assign cur_mode   = {op_word[6], op_word[3:0]};
    // No new operand while a result is pending for the reader
    assign take_first = (state == ST_IDLE) && op_valid && !reader_busy && !ea_ok;
    assign take_ext   = (state == ST_EXT) && op_valid;
    assign op_take    = take_first || take_ext;

    always_comb begin
        done_first = 1'b0;
        need_ext   = 1'b0;
        casez (cur_mode)
            5'b0_????, 5'b1_0000, 5'b1_0100, 5'b1_0101: done_first = 1'b1;
            5'b1_0001, 5'b1_0010: need_ext = 1'b1;
            5'b1_0011: begin
                done_first = (op_word[9:8] == 2'd0);
                need_ext   = (op_word[9:8] == 2'd1) || (op_word[9:8] == 2'd2);
            end
            default: ;  // Consumed, no result
        endcase
    end

    // Index is zero whenever aux_sel holds the null code
    assign idx_ext = idx16 ?
        {{(`EA_ADDR_W-16){regs.aux_rdata[15]}}, regs.aux_rdata[15:0]} :
        {{(`EA_ADDR_W-8){regs.aux_rdata[7]}}, regs.aux_rdata[7:0]};

    assign ea = regs.rdata[`EA_ADDR_W-1:0] + offset + idx_ext;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= ST_IDLE;
            ea_ok    <= 1'b0;
            regs.inc <= 1'b0;
            regs.dec <= 1'b0;
        end else begin
            ea_ok    <= (take_first && done_first) || take_ext;
            regs.inc <= take_first && (cur_mode == 5'b1_0101);  // Post-increment
            regs.dec <= take_first && (cur_mode == 5'b1_0100);  // Pre-decrement
            if (take_first && need_ext) begin
                state <= ST_EXT;
            end else if (take_ext) begin
                state <= ST_IDLE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_first) begin
            mode         <= cur_mode;
            variant      <= op_word[9:8];
            idx16        <= op_word[10];
            regs.step    <= op_word[9:8];
            regs.aux_sel <= `EA_NULL_REG;
            offset       <= '0;
            casez (cur_mode)
                5'b0_????: begin
                    regs.sel <= full_reg(op_word[2:0]);
                    if (op_word[3]) begin
                        offset <= {{(`EA_ADDR_W-8){op_word[15]}}, op_word[15:8]};
                    end
                end
                5'b1_0000, 5'b1_0001, 5'b1_0010: begin
                    regs.sel    <= `EA_NULL_REG;  // Absolute, low byte from word 1
                    offset[7:0] <= op_word[15:8];
                end
                5'b1_0011, 5'b1_0101: regs.sel <= {op_word[15:10], 2'b00};
                5'b1_0100: begin
                    regs.sel <= {op_word[15:10], 2'b00};
                    offset   <= '0 - addr_t'(step_size(op_word[9:8]));  // Reg minus step
                end
                default: regs.sel <= `EA_NULL_REG;
            endcase
        end else if (take_ext) begin
            case (mode)
                5'b1_0001: offset[`EA_ADDR_W-1:8] <= {{8{op_word[7]}}, op_word[7:0]};
                5'b1_0010: offset[`EA_ADDR_W-1:8] <= op_word;
                5'b1_0011: begin
                    if (variant == 2'd1) begin
                        offset <= {{(`EA_ADDR_W-16){op_word[15]}}, op_word};  // d16
                    end else begin
                        regs.sel     <= op_word[7:0];
                        regs.aux_sel <= op_word[15:8];
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

//--- hdl/ea_reg_bank.sv
// Register bank for the address unit
// XWA..XSP with base and index read ports, step update and external load
module ea_reg_bank (
    input  logic              clk,
    input  logic              rst,
    reg_access_if.slave       regs,
    input  logic              load,
    input  ea_pkg::reg_code_t load_sel,
    input  ea_pkg::reg_word_t load_data
);
    import ea_pkg::*;

    reg_word_t bank [8];
    reg_word_t step_amt;
    logic      step_en;
    logic      load_en;

    // Only codes with the top three bits set map onto a register
    function automatic logic is_full(input reg_code_t code);
        return code[7:5] == 3'b111;
    endfunction

    assign regs.rdata     = is_full(regs.sel) ? bank[regs.sel[4:2]] : '0;
    assign regs.aux_rdata = is_full(regs.aux_sel) ? bank[regs.aux_sel[4:2]] : '0;

    assign step_amt = step_size(regs.step);
    // Loads stay open during reset so registers can be preset
    assign step_en  = !rst && (regs.inc || regs.dec) && is_full(regs.sel);
    assign load_en  = load && is_full(load_sel);

    always_ff @(posedge clk) begin
        for (int i = 0; i < 8; i++) begin
            if (load_en && (load_sel[4:2] == i)) begin
                bank[i] <= load_data;  // Load wins over a step
            end else if (step_en && (regs.sel[4:2] == i)) begin
                if (regs.inc) begin
                    bank[i] <= bank[i] + step_amt;
                end else begin
                    bank[i] <= bank[i] - step_amt;
                end
            end
        end
    end

endmodule

//--- hdl/op_prefetch.sv
// Operand prefetcher
// Reads operand words upward from address 0 into a small queue
`include "ea_params.svh"

module op_prefetch (
    input  logic             clk,
    input  logic             rst,
    mem_port_if.requester    mem,
    output ea_pkg::op_word_t op_word,
    output logic             op_valid,
    input  logic             op_take
);
    import ea_pkg::*;

    localparam int DEPTH = `EA_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    op_word_t         queue [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;       // Words held
    logic [PTR_W:0]   slots;       // Words held plus the one in flight
    logic             req_q;
    addr_t            fetch_addr;
    logic             issue;

    assign issue = !req_q && (slots < DEPTH);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req_q      <= 1'b0;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            slots      <= '0;
            fetch_addr <= '0;
        end else begin
            if (issue) begin
                req_q <= 1'b1;
            end else if (mem.ack) begin
                req_q <= 1'b0;
            end
            if (mem.ack) begin
                wr_ptr     <= wr_ptr + 1'b1;
                fetch_addr <= fetch_addr + 2'd2;  // Next word
            end
            if (op_take) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (PTR_W+1)'(mem.ack) - (PTR_W+1)'(op_take);
            slots <= slots + (PTR_W+1)'(issue) - (PTR_W+1)'(op_take);
        end
    end

    always_ff @(posedge clk) begin
        if (mem.ack) begin
            queue[wr_ptr] <= mem.rdata;
        end
    end

    assign mem.req  = req_q;
    assign mem.addr = fetch_addr;
    assign op_word  = queue[rd_ptr];  // Head word
    assign op_valid = (count != '0);

endmodule

//--- hdl/mem_arbiter.sv
// Memory arbiter
// Fixed priority for the data reader over the prefetcher on one memory port
module mem_arbiter (
    input  logic             clk,
    input  logic             rst,
    mem_port_if.arbiter      fetch_port,
    mem_port_if.arbiter      data_port,
    output logic             mem_req,
    output ea_pkg::addr_t    mem_addr,
    input  ea_pkg::op_word_t mem_rdata,
    input  logic             mem_ack
);
    import ea_pkg::*;

    logic  busy;        // Request in flight
    logic  grant_data;
    addr_t addr_q;

    // Grant only moves while the bus is idle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy       <= 1'b0;
            grant_data <= 1'b0;
        end else if (!busy) begin
            if (data_port.req) begin
                grant_data <= 1'b1;
                busy       <= 1'b1;
            end else if (fetch_port.req) begin
                grant_data <= 1'b0;
                busy       <= 1'b1;
            end
        end else if (mem_ack) begin
            busy <= 1'b0;
        end
    end

    // Requesters hold addr until ack, so it is safe to capture at grant
    always_ff @(posedge clk) begin
        if (!busy) begin
            addr_q <= data_port.req ? data_port.addr : fetch_port.addr;
        end
    end

    assign mem_req  = busy;
    assign mem_addr = addr_q;

    assign data_port.ack    = busy && grant_data && mem_ack;
    assign fetch_port.ack   = busy && !grant_data && mem_ack;
    assign data_port.rdata  = mem_rdata;
    assign fetch_port.rdata = mem_rdata;

endmodule

//--- hdl/ea_data_reader.sv
// Data reader
// Fetches the memory word at each effective address
module ea_data_reader (
    input  logic             clk,
    input  logic             rst,
    input  ea_pkg::addr_t    ea,
    input  logic             ea_ok,
    output logic             busy,
    mem_port_if.requester    mem,
    output ea_pkg::op_word_t data,
    output logic             data_valid
);
    import ea_pkg::*;

    typedef enum logic {RD_IDLE, RD_BUSY} rd_state_t;

    rd_state_t state;
    addr_t     addr_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= RD_IDLE;
            data_valid <= 1'b0;
        end else begin
            data_valid <= 1'b0;
            if (state == RD_IDLE && ea_ok) begin
                state <= RD_BUSY;
            end else if (state == RD_BUSY && mem.ack) begin
                state      <= RD_IDLE;
                data_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == RD_IDLE && ea_ok) begin
            addr_q <= ea;
        end
        if (mem.ack) begin
            data <= mem.rdata;
        end
    end

    assign busy     = (state == RD_BUSY);
    assign mem.req  = busy;   // Held until ack
    assign mem.addr = addr_q;

endmodule

//--- hdl/ea_unit_top.sv
// Effective-address unit top level
// Prefetcher, address generator, register bank and data reader on one memory port
module ea_unit_top (
    input  logic              clk,
    input  logic              rst,
    // External memory
    output logic              mem_req,
    output ea_pkg::addr_t     mem_addr,
    input  ea_pkg::op_word_t  mem_rdata,
    input  logic              mem_ack,
    // Register preload
    input  logic              reg_load,
    input  ea_pkg::reg_code_t reg_load_sel,
    input  ea_pkg::reg_word_t reg_load_data,
    // Results
    output ea_pkg::addr_t     ea,
    output logic              ea_ok,
    output ea_pkg::op_word_t  data,
    output logic              data_valid
);
    import ea_pkg::*;

    op_word_t op_word;
    logic     op_valid;
    logic     op_take;
    logic     reader_busy;

    mem_port_if   fetch_bus ();
    mem_port_if   data_bus ();
    reg_access_if regs_bus ();

    op_prefetch u_prefetch (
        .clk      (clk),
        .rst      (rst),
        .mem      (fetch_bus),
        .op_word  (op_word),
        .op_valid (op_valid),
        .op_take  (op_take)
    );

    ea_addr_gen u_addr_gen (
        .clk         (clk),
        .rst         (rst),
        .op_word     (op_word),
        .op_valid    (op_valid),
        .op_take     (op_take),
        .regs        (regs_bus),
        .ea          (ea),
        .ea_ok       (ea_ok),
        .reader_busy (reader_busy)
    );

    ea_reg_bank u_reg_bank (
        .clk       (clk),
        .rst       (rst),
        .regs      (regs_bus),
        .load      (reg_load),
        .load_sel  (reg_load_sel),
        .load_data (reg_load_data)
    );

    ea_data_reader u_data_reader (
        .clk        (clk),
        .rst        (rst),
        .ea         (ea),
        .ea_ok      (ea_ok),
        .busy       (reader_busy),
        .mem        (data_bus),
        .data       (data),
        .data_valid (data_valid)
    );

    mem_arbiter u_arbiter (
        .clk        (clk),
        .rst        (rst),
        .fetch_port (fetch_bus),
        .data_port  (data_bus),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .mem_rdata  (mem_rdata),
        .mem_ack    (mem_ack)
    );

endmodule

//--- tb/tb_mem_model.sv
// Memory responder for the EA unit testbench
// Acks after 0 to 3 random cycles, program image below 0x100, address pattern above
module tb_mem_model (
    input  logic             clk,
    input  logic             rst,
    input  logic             mem_req,
    input  ea_pkg::addr_t    mem_addr,
    output ea_pkg::op_word_t mem_rdata,
    output logic             mem_ack
);
    import ea_pkg::*;

    localparam int unsigned SEED = 32'h192c_06f6;

    op_word_t    image [128];  // Written by the testbench before reset ends
    logic        active;       // Ack pending for an accepted request
    int unsigned wait_left;

    function automatic op_word_t read_word(input addr_t a);
        op_word_t w;
        if (a < 24'h000100) begin
            w = image[a[7:1]];
        end else begin
            w = a[15:0] ^ 16'h5a5a;
        end
        return w;
    endfunction

    initial begin
        void'($urandom(SEED));
        mem_ack   = 1'b0;
        mem_rdata = '0;
        active    = 1'b0;
        wait_left = 0;
        forever begin
            @(posedge clk);
            #1;
            mem_ack = 1'b0;  // One-cycle ack
            if (rst) begin
                active = 1'b0;
            end else begin
                if (mem_req && !active) begin
                    active    = 1'b1;
                    wait_left = $urandom % 4;
                end
                if (active && wait_left == 0) begin
                    mem_ack   = 1'b1;
                    mem_rdata = read_word(mem_addr);
                    active    = 1'b0;
                end else if (active) begin
                    wait_left = wait_left - 1;
                end
            end
        end
    end

endmodule

//--- tb/tb_ea_unit.sv
// EA unit testbench
// Walks a table of operand descriptors, checks each address and the word read there
`include "ea_params.svh"

module tb_ea_unit;
    import ea_pkg::*;

    localparam int        MAX_CASES = 32;
    localparam int        TIMEOUT   = 200;  // Cycles per wait
    localparam reg_code_t XWA       = `EA_FULL_REG_BASE;
    localparam reg_code_t XBC       = `EA_FULL_REG_BASE + 8'd4;
    localparam reg_code_t XDE       = `EA_FULL_REG_BASE + 8'd8;
    localparam reg_word_t XWA_INIT  = 32'h0012_3400;
    localparam reg_word_t XBC_INIT  = 32'h0000_2000;
    localparam reg_word_t XDE_INIT  = 32'h0001_80e8;  // -24 as 8 bits, -0x7f18 as 16 bits

    logic      clk;
    logic      rst;
    logic      mem_req;
    addr_t     mem_addr;
    op_word_t  mem_rdata;
    logic      mem_ack;
    logic      reg_load;
    reg_code_t reg_load_sel;
    reg_word_t reg_load_data;
    addr_t     ea;
    logic      ea_ok;
    op_word_t  data;
    logic      data_valid;

    string    case_name [MAX_CASES];
    int       case_len  [MAX_CASES];
    op_word_t case_w0   [MAX_CASES];
    op_word_t case_w1   [MAX_CASES];
    addr_t    case_ea   [MAX_CASES];
    int       num_cases;
    op_word_t prog [128];
    addr_t    data_addr;
    int       n;

    ea_unit_top dut (
        .clk           (clk),
        .rst           (rst),
        .mem_req       (mem_req),
        .mem_addr      (mem_addr),
        .mem_rdata     (mem_rdata),
        .mem_ack       (mem_ack),
        .reg_load      (reg_load),
        .reg_load_sel  (reg_load_sel),
        .reg_load_data (reg_load_data),
        .ea            (ea),
        .ea_ok         (ea_ok),
        .data          (data),
        .data_valid    (data_valid)
    );

    tb_mem_model u_mem (
        .clk       (clk),
        .rst       (rst),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_rdata (mem_rdata),
        .mem_ack   (mem_ack)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Regression failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (exp !== act) begin
            report_failure($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_word(input string name, input op_word_t exp, input op_word_t act);
        if (exp !== act) begin
            report_failure($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            report_failure($sformatf("mismatch %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic add_case(input string name, input int len, input op_word_t w0,
                            input op_word_t w1, input addr_t exp_ea);
        case_name[num_cases] = name;
        case_len[num_cases]  = len;
        case_w0[num_cases]   = w0;
        case_w1[num_cases]   = w1;
        case_ea[num_cases]   = exp_ea;
        num_cases++;
    endtask

    task automatic build_table();
        reg_word_t xbc;  // XBC as it moves through the step modes
        xbc       = XBC_INIT;
        num_cases = 0;
        add_case("short_xwa", 1, 16'h0000, 16'h0000, XWA_INIT[23:0]);
        add_case("short_xbc_pos", 1, 16'h3509, 16'h0000, xbc[23:0] + 24'h000035);
        add_case("short_xwa_neg", 1, 16'hf008, 16'h0000, XWA_INIT[23:0] - 24'h000010);
        add_case("abs8", 1, 16'hf240, 16'h0000, 24'h0000f2);  // Lands in the image
        add_case("abs16_pos", 2, 16'h3441, 16'h7712, 24'h001234);
        add_case("abs16_neg", 2, 16'h3441, 16'h0085, 24'hff8534);
        add_case("abs24", 2, 16'h5642, 16'h3a4c, 24'h3a4c56);
        add_case("ind_xbc", 1, 16'he443, 16'h0000, xbc[23:0]);
        add_case("d16_pos", 2, 16'he143, 16'h1234, XWA_INIT[23:0] + 24'h001234);
        add_case("d16_neg", 2, 16'he543, 16'hff00, xbc[23:0] - 24'h000100);
        // Extension word is index code high, base code low
        add_case("idx8_neg", 2, 16'he243, 16'he8e0, XWA_INIT[23:0] - 24'd24);
        add_case("idx16_neg", 2, 16'he643, 16'he8e0, XWA_INIT[23:0] - 24'h007f18);
        add_case("idx16_pos", 2, 16'he643, 16'he4e0, XWA_INIT[23:0] + xbc[23:0]);
        xbc = xbc - 32'd1;
        add_case("predec_1", 1, 16'he444, 16'h0000, xbc[23:0]);
        xbc = xbc - 32'd2;
        add_case("predec_2", 1, 16'he544, 16'h0000, xbc[23:0]);
        xbc = xbc - 32'd4;
        add_case("predec_4", 1, 16'he644, 16'h0000, xbc[23:0]);
        add_case("postinc_4", 1, 16'he645, 16'h0000, xbc[23:0]);
        xbc = xbc + 32'd4;
        add_case("postinc_2", 1, 16'he545, 16'h0000, xbc[23:0]);
        xbc = xbc + 32'd2;
        add_case("postinc_1", 1, 16'he445, 16'h0000, xbc[23:0]);
        xbc = xbc + 32'd1;
        add_case("ind_xbc_end", 1, 16'he443, 16'h0000, xbc[23:0]);
    endtask

    // Operand words back to back from address 0, then filler of an unused mode
    task automatic lay_out_image();
        int i;
        int len;
        len = 0;
        for (i = 0; i < num_cases; i++) begin
            prog[len] = case_w0[i];
            len++;
            if (case_len[i] == 2) begin
                prog[len] = case_w1[i];
                len++;
            end
        end
        for (i = len; i < 128; i++) begin
            prog[i] = {1'b0, i[6:0], 8'h46};
        end
        for (i = 0; i < 128; i++) begin
            u_mem.image[i] = prog[i];
        end
    endtask

    function automatic op_word_t expect_word(input addr_t a);
        op_word_t w;
        if (a < 24'h000100) begin
            w = prog[a[7:1]];
        end else begin
            w = a[15:0] ^ 16'h5a5a;
        end
        return w;
    endfunction

    task automatic load_reg(input reg_code_t code, input reg_word_t value);
        reg_load_sel  = code;
        reg_load_data = value;
        @(posedge clk);
        #1;
    endtask

    task automatic await_ea_ok(input string name);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                report_failure($sformatf("timeout waiting for ea_ok in case %s", name));
            end
        end while (!ea_ok);
    endtask

    task automatic await_data_valid(input string name, output addr_t acked_addr);
        int cycles;
        cycles     = 0;
        acked_addr = 'x;
        do begin
            @(negedge clk);
            cycles++;
            if (mem_ack) begin
                acked_addr = mem_addr;  // Last ack before data_valid is the reader's
            end
            if (cycles > TIMEOUT) begin
                report_failure($sformatf("timeout waiting for data_valid in case %s", name));
            end
        end while (!data_valid);
    endtask

    initial begin
        rst           = 1'b1;
        reg_load      = 1'b1;
        reg_load_sel  = '0;
        reg_load_data = '0;
        build_table();
        lay_out_image();
        load_reg(XWA, XWA_INIT);  // One load per reset cycle
        load_reg(XBC, XBC_INIT);
        load_reg(XDE, XDE_INIT);
        reg_load = 1'b0;
        rst      = 1'b0;
        @(negedge clk);
        check_bit("reset_ea_ok", 1'b0, ea_ok);
        check_bit("reset_data_valid", 1'b0, data_valid);
        check_bit("reset_mem_req", 1'b0, mem_req);
        for (n = 0; n < num_cases; n++) begin
            await_ea_ok(case_name[n]);
            check_addr(case_name[n], case_ea[n], ea);
            await_data_valid(case_name[n], data_addr);
            check_addr($sformatf("%s_mem_addr", case_name[n]), case_ea[n], data_addr);
            check_word(case_name[n], expect_word(case_ea[n]), data);
        end
        $display("Regression passed");
        $finish;
    end

endmodule

//--- src.f
+incdir+hdl
hdl/ea_pkg.sv
hdl/mem_port_if.sv
hdl/reg_access_if.sv
hdl/ea_addr_gen.sv
hdl/ea_reg_bank.sv
hdl/op_prefetch.sv
hdl/mem_arbiter.sv
hdl/ea_data_reader.sv
hdl/ea_unit_top.sv
tb/tb_mem_model.sv
tb/tb_ea_unit.sv
